// File: include/conv_in_consts.svh
`ifndef CONV_IN_CONSTS_SVH
`define CONV_IN_CONSTS_SVH

// Word and beat geometry
`define WORD_WIDTH    8
`define UNITS         2
`define KERNEL_H_MAX  3

// Pixel beat carries the edge rows needed by the tallest kernel
`define IM_WORDS      (`UNITS + `KERNEL_H_MAX - 1)

`define CORES         2
`define KERNEL_W_MAX  3

// One weight row for every core
`define W_WORDS       (`CORES * `KERNEL_W_MAX)

// Column count in the weight config beat
`define COLS_BITS     8

`endif

// File: src/conv_in_pkg.sv
`default_nettype none

`include "conv_in_consts.svh"

package conv_in_pkg;

  typedef logic [`WORD_WIDTH-1:0] word_t;

  typedef word_t [`W_WORDS-1:0] w_words_t;

  // Config beat layout, low word first
  typedef struct packed {
    logic [(`W_WORDS-2)*`WORD_WIDTH-1:0] unused;
    logic [`COLS_BITS-1:0]               n_cols;
    word_t                               kernel_h;
  } w_cfg_t;

  // Same weight beat, seen as config or as weights
  typedef union packed {
    w_cfg_t   cfg;
    w_words_t words;
  } w_beat_u;

  typedef struct packed {
    logic [1:0] row;
    logic       col_last;
  } conv_flags_t;

endpackage

`default_nettype wire

// File: src/conv_stream_if.sv
`default_nettype none

interface conv_stream_if #(
  parameter int WIDTH = 8
);

  logic             valid;
  logic             ready;
  logic [WIDTH-1:0] data;
  logic             last;
  // Kernel row index of the beat
  logic [1:0]       row;

  modport src (output valid, output data, output last, output row, input ready);

  modport snk (input valid, input data, input last, input row, output ready);

endinterface

`default_nettype wire

// File: src/pixel_shifter.sv
`default_nettype none

`include "conv_in_consts.svh"

module pixel_shifter (
  input  wire logic                              aclk,
  input  wire logic                              i_rst_n,
  input  wire logic [1:0]                        i_kernel_h,
  input  wire logic                              i_px_valid,
  output logic                                   o_px_ready,
  input  wire logic [`IM_WORDS*`WORD_WIDTH-1:0]  i_px_data,
  input  wire logic                              i_px_last,
  conv_stream_if.src                             o_win
);

  logic                             valid_q;
  logic                             ready_q;
  logic [1:0]                       row_q;
  logic [`IM_WORDS*`WORD_WIDTH-1:0] col_q;
  logic                             last_q;
  logic                             px_fire;
  logic                             win_fire;
  logic                             row_end;

  assign px_fire  = i_px_valid && ready_q;
  assign win_fire = valid_q && o_win.ready;
  assign row_end  = (row_q == i_kernel_h - 2'd1);

  assign o_px_ready = ready_q;

  always_ff @(posedge aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      valid_q <= 1'b0;
      ready_q <= 1'b0;
      row_q   <= 2'd0;
    end else begin
      if (px_fire) begin
        valid_q <= 1'b1;
        ready_q <= 1'b0;
        row_q   <= 2'd0;
      end else if (win_fire) begin
        if (row_end) begin
          valid_q <= 1'b0;
          ready_q <= 1'b1;
        end else begin
          row_q <= row_q + 2'd1;
        end
      end else if (!valid_q) begin
        // Open up once out of reset
        ready_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (px_fire) begin
      col_q  <= i_px_data;
      last_q <= i_px_last;
    end
  end

  // Window k holds column words k and k+1
  assign o_win.valid = valid_q;
  assign o_win.data  = col_q[row_q*`WORD_WIDTH +: `UNITS*`WORD_WIDTH];
  assign o_win.row   = row_q;
  assign o_win.last  = last_q;

endmodule

`default_nettype wire

// File: src/weight_rotator.sv
`default_nettype none

`include "conv_in_consts.svh"

module weight_rotator
  import conv_in_pkg::*;
(
  input  wire logic    aclk,
  input  wire logic    i_rst_n,
  input  wire logic    i_w_valid,
  output logic         o_w_ready,
  input  wire w_beat_u i_w_data,
  input  wire logic    i_w_last,
  output logic [1:0]   o_kernel_h,
  conv_stream_if.src   o_wrow
);

  localparam logic [1:0] ST_CFG    = 2'd0;
  localparam logic [1:0] ST_ROWS   = 2'd1;
  localparam logic [1:0] ST_REPLAY = 2'd2;

  logic [1:0]                      state_q;
  logic [1:0]                      kernel_h_q;
  logic [`COLS_BITS-1:0]           n_cols_q;
  logic [1:0]                      wr_idx_q;
  logic [1:0]                      rd_row_q;
  logic [`COLS_BITS-1:0]           col_cnt_q;
  logic [`W_WORDS*`WORD_WIDTH-1:0] w_rows_q [`KERNEL_H_MAX];
  logic                            w_fire;
  logic                            rot_fire;
  logic                            row_end;
  logic                            col_end;

  assign o_w_ready = (state_q != ST_REPLAY);
  assign w_fire    = i_w_valid && o_w_ready;
  assign rot_fire  = o_wrow.valid && o_wrow.ready;
  assign row_end   = (rd_row_q == kernel_h_q - 2'd1);
  assign col_end   = (col_cnt_q == n_cols_q - 1'b1);

  always_ff @(posedge aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q    <= ST_CFG;
      kernel_h_q <= 2'd1;
      n_cols_q   <= '0;
      wr_idx_q   <= 2'd0;
      rd_row_q   <= 2'd0;
      col_cnt_q  <= '0;
    end else begin
      case (state_q)
        ST_CFG: begin
          if (w_fire) begin
            kernel_h_q <= i_w_data.cfg.kernel_h[1:0];
            n_cols_q   <= i_w_data.cfg.n_cols;
            wr_idx_q   <= 2'd0;
            state_q    <= ST_ROWS;
          end
        end
        ST_ROWS: begin
          if (w_fire) begin
            wr_idx_q <= wr_idx_q + 2'd1;
            if (i_w_last) begin
              rd_row_q  <= 2'd0;
              col_cnt_q <= '0;
              state_q   <= ST_REPLAY;
            end
          end
        end
        ST_REPLAY: begin
          if (rot_fire) begin
            if (row_end) begin
              rd_row_q <= 2'd0;
              // Whole image done, wait for the next packet
              if (col_end) state_q <= ST_CFG;
              else col_cnt_q <= col_cnt_q + 1'b1;
            end else begin
              rd_row_q <= rd_row_q + 2'd1;
            end
          end
        end
        default: state_q <= ST_CFG;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (w_fire && state_q == ST_ROWS && wr_idx_q < 2'(`KERNEL_H_MAX)) begin
      w_rows_q[wr_idx_q] <= i_w_data.words;
    end
  end

  assign o_kernel_h   = kernel_h_q;
  assign o_wrow.valid = (state_q == ST_REPLAY);
  assign o_wrow.data  = w_rows_q[rd_row_q];
  assign o_wrow.row   = rd_row_q;
  assign o_wrow.last  = row_end && col_end;

endmodule

`default_nettype wire

// File: src/beat_joiner.sv
`default_nettype none

`include "conv_in_consts.svh"

module beat_joiner
  import conv_in_pkg::*;
(
  input  wire logic                             aclk,
  input  wire logic                             i_rst_n,
  input  wire logic [1:0]                       i_kernel_h,
  conv_stream_if.snk                            i_px,
  conv_stream_if.snk                            i_w,
  output logic                                  o_valid,
  input  wire logic                             i_ready,
  output logic [`UNITS*`WORD_WIDTH-1:0]         o_px_data,
  output logic [`W_WORDS*`WORD_WIDTH-1:0]       o_w_data,
  output conv_flags_t                           o_flags,
  output logic                                  o_last
);

  logic        valid_q;
  logic        take;
  logic        fire;
  conv_flags_t flags_d;

  // Output slot free or emptying this cycle
  assign take = !valid_q || i_ready;
  assign fire = i_px.valid && i_w.valid && take;

  assign i_px.ready = fire;
  assign i_w.ready  = fire;

  assign flags_d.row      = i_px.row;
  assign flags_d.col_last = (i_px.row == i_kernel_h - 2'd1);

  always_ff @(posedge aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      valid_q <= 1'b0;
    end else if (fire) begin
      valid_q <= 1'b1;
    end else if (i_ready) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (fire) begin
      o_px_data <= i_px.data;
      o_w_data  <= i_w.data;
      o_flags   <= flags_d;
      o_last    <= i_px.last && flags_d.col_last;
    end
  end

  assign o_valid = valid_q;

endmodule

`default_nettype wire

// File: src/conv_input_pipe.sv
`default_nettype none

`include "conv_in_consts.svh"

module conv_input_pipe
  import conv_in_pkg::*;
(
  input  wire logic                              aclk,
  input  wire logic                              i_rst_n,
  input  wire logic                              i_px_valid,
  output logic                                   o_px_ready,
  input  wire logic [`IM_WORDS*`WORD_WIDTH-1:0]  i_px_data,
  input  wire logic                              i_px_last,
  input  wire logic                              i_w_valid,
  output logic                                   o_w_ready,
  input  wire logic [`W_WORDS*`WORD_WIDTH-1:0]   i_w_data,
  input  wire logic                              i_w_last,
  output logic                                   o_m_valid,
  input  wire logic                              i_m_ready,
  output logic [`UNITS*`WORD_WIDTH-1:0]          o_m_px_data,
  output logic [`W_WORDS*`WORD_WIDTH-1:0]        o_m_w_data,
  output logic [1:0]                             o_m_row,
  output logic                                   o_m_col_last,
  output logic                                   o_m_last
);

  logic [1:0]  kernel_h;
  conv_flags_t flags;

  conv_stream_if #(.WIDTH(`UNITS*`WORD_WIDTH))   px_s ();
  conv_stream_if #(.WIDTH(`W_WORDS*`WORD_WIDTH)) w_s ();

  pixel_shifter shifter_i (
    .aclk       (aclk),
    .i_rst_n    (i_rst_n),
    .i_kernel_h (kernel_h),
    .i_px_valid (i_px_valid),
    .o_px_ready (o_px_ready),
    .i_px_data  (i_px_data),
    .i_px_last  (i_px_last),
    .o_win      (px_s.src)
  );

  weight_rotator rotator_i (
    .aclk       (aclk),
    .i_rst_n    (i_rst_n),
    .i_w_valid  (i_w_valid),
    .o_w_ready  (o_w_ready),
    .i_w_data   (i_w_data),
    .i_w_last   (i_w_last),
    .o_kernel_h (kernel_h),
    .o_wrow     (w_s.src)
  );

  beat_joiner joiner_i (
    .aclk       (aclk),
    .i_rst_n    (i_rst_n),
    .i_kernel_h (kernel_h),
    .i_px       (px_s.snk),
    .i_w        (w_s.snk),
    .o_valid    (o_m_valid),
    .i_ready    (i_m_ready),
    .o_px_data  (o_m_px_data),
    .o_w_data   (o_m_w_data),
    .o_flags    (flags),
    .o_last     (o_m_last)
  );

  assign o_m_row      = flags.row;
  assign o_m_col_last = flags.col_last;

endmodule

`default_nettype wire

// File: bench/conv_input_pipe_tb.sv
`default_nettype none

`include "conv_in_consts.svh"

module conv_input_pipe_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int PXW = `UNITS * `WORD_WIDTH;
  localparam int WW = `W_WORDS * `WORD_WIDTH;
  localparam int CW = `IM_WORDS * `WORD_WIDTH;
  // Beat record holds last, col_last, row, weights and pixels from the top down
  localparam int BEAT_W = PXW + WW + 4;
  // All tests together take a few hundred cycles
  localparam int MAX_CYCLES = 4000;

  logic aclk;
  logic i_rst_n;
  logic i_px_valid;
  logic o_px_ready;
  logic [CW-1:0] i_px_data;
  logic i_px_last;
  logic i_w_valid;
  logic o_w_ready;
  logic [WW-1:0] i_w_data;
  logic i_w_last;
  logic o_m_valid;
  logic i_m_ready;
  logic [PXW-1:0] o_m_px_data;
  logic [WW-1:0] o_m_w_data;
  logic [1:0] o_m_row;
  logic o_m_col_last;
  logic o_m_last;

  integer seed = 32'h94f5_1c73;
  integer w_seed;
  integer px_seed;
  integer ready_seed;
  logic rand_ready;
  logic gaps;
  int cycles = 0;
  int errors = 0;
  int checks = 0;
  int tests = 0;

  logic [`WORD_WIDTH-1:0] px_words [4][`IM_WORDS];
  logic [WW-1:0] w_rows [2][`KERNEL_H_MAX];
  logic [BEAT_W-1:0] exp_q [$];
  logic [BEAT_W-1:0] got_q [$];

  conv_input_pipe dut_i (
    .aclk         (aclk),
    .i_rst_n      (i_rst_n),
    .i_px_valid   (i_px_valid),
    .o_px_ready   (o_px_ready),
    .i_px_data    (i_px_data),
    .i_px_last    (i_px_last),
    .i_w_valid    (i_w_valid),
    .o_w_ready    (o_w_ready),
    .i_w_data     (i_w_data),
    .i_w_last     (i_w_last),
    .o_m_valid    (o_m_valid),
    .i_m_ready    (i_m_ready),
    .o_m_px_data  (o_m_px_data),
    .o_m_w_data   (o_m_w_data),
    .o_m_row      (o_m_row),
    .o_m_col_last (o_m_col_last),
    .o_m_last     (o_m_last)
  );

  initial aclk = 1'b0;
  always #20 aclk = ~aclk;

  always @(posedge aclk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Test failures found");
      $finish;
    end
  end

  always @(posedge aclk) begin
    i_m_ready <= !rand_ready || (($random(ready_seed) & 1) == 1);
  end

  // Output monitor
  always @(posedge aclk) begin
    if (i_rst_n && o_m_valid && i_m_ready) begin
      got_q.push_back({o_m_last, o_m_col_last, o_m_row, o_m_w_data, o_m_px_data});
    end
  end

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic fill_pixels();
    for (int c = 0; c < 4; c++) begin
      for (int j = 0; j < `IM_WORDS; j++) px_words[c][j] = 8'($random(seed));
    end
  endtask

  task automatic fill_weights(input int set);
    for (int k = 0; k < `KERNEL_H_MAX; k++) begin
      w_rows[set][k] = {16'($random(seed)), 32'($random(seed))};
    end
  endtask

  // Reference model emits one beat per kernel row of a column
  task automatic expect_column(input int c, input int set, input int kh, input bit last_col);
    logic [PXW-1:0] px;
    for (int k = 0; k < kh; k++) begin
      px = {px_words[c][k+1], px_words[c][k]};
      exp_q.push_back({last_col && (k == kh - 1), k == kh - 1, 2'(k), w_rows[set][k], px});
    end
  endtask

  task automatic push_w_beat(input logic [WW-1:0] data, input logic last);
    int gap;
    gap = gaps ? int'($unsigned($random(w_seed)) % 3) : 0;
    if (gap > 0) begin
      i_w_valid <= 1'b0;
      repeat (gap) @(posedge aclk);
    end
    i_w_valid <= 1'b1;
    i_w_data  <= data;
    i_w_last  <= last;
    @(posedge aclk);
    while (!o_w_ready) @(posedge aclk);
  endtask

  task automatic push_wpacket(input int set, input int kh, input int ncols);
    push_w_beat({{(WW-16){1'b0}}, 8'(ncols), 8'(kh)}, 1'b0);
    for (int k = 0; k < kh; k++) push_w_beat(w_rows[set][k], k == kh - 1);
    i_w_valid <= 1'b0;
    i_w_last  <= 1'b0;
  endtask

  task automatic push_image(input int ncols);
    logic [CW-1:0] col;
    int gap;
    for (int c = 0; c < ncols; c++) begin
      for (int j = 0; j < `IM_WORDS; j++) col[j*`WORD_WIDTH +: `WORD_WIDTH] = px_words[c][j];
      gap = gaps ? int'($unsigned($random(px_seed)) % 3) : 0;
      if (gap > 0) begin
        i_px_valid <= 1'b0;
        repeat (gap) @(posedge aclk);
      end
      i_px_valid <= 1'b1;
      i_px_data  <= col;
      i_px_last  <= (c == ncols - 1);
      @(posedge aclk);
      while (!o_px_ready) @(posedge aclk);
    end
    i_px_valid <= 1'b0;
    i_px_last  <= 1'b0;
  endtask

  task automatic finish_test(input string name);
    int errs_before;
    int n;
    logic [BEAT_W-1:0] g;
    logic [BEAT_W-1:0] e;
    errs_before = errors;
    while (got_q.size() < exp_q.size()) @(posedge aclk);
    // Room for any extra beat to show up
    repeat (8) @(posedge aclk);
    check("beat count", got_q.size(), exp_q.size());
    n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
    for (int i = 0; i < n; i++) begin
      g = got_q[i];
      e = exp_q[i];
      check("o_m_px_data", g[PXW-1:0], e[PXW-1:0]);
      check("o_m_w_data", g[PXW +: WW], e[PXW +: WW]);
      check("o_m_row", g[PXW+WW +: 2], e[PXW+WW +: 2]);
      check("o_m_col_last", g[BEAT_W-2], e[BEAT_W-2]);
      check("o_m_last", g[BEAT_W-1], e[BEAT_W-1]);
    end
    tests++;
    $display("%s: %s", name, (errors == errs_before) ? "ok" : "FAILED");
    exp_q.delete();
    got_q.delete();
  endtask

  task automatic test_after_reset();
    int errs_before;
    errs_before = errors;
    check("o_m_valid", o_m_valid, 1'b0);
    check("o_w_ready", o_w_ready, 1'b1);
    tests++;
    $display("after reset: %s", (errors == errs_before) ? "ok" : "FAILED");
  endtask

  task automatic test_kernel3();
    fill_pixels();
    fill_weights(0);
    for (int c = 0; c < 4; c++) expect_column(c, 0, 3, c == 3);
    push_wpacket(0, 3, 4);
    push_image(4);
    finish_test("kernel 3x3");
  endtask

  task automatic test_kernel1();
    fill_weights(1);
    for (int c = 0; c < 4; c++) expect_column(c, 1, 1, c == 3);
    push_wpacket(1, 1, 4);
    push_image(4);
    finish_test("kernel 1x1");
  endtask

  // Same data as the 3x3 test under stalls on both sides
  task automatic test_backpressure();
    rand_ready = 1'b1;
    gaps = 1'b1;
    for (int c = 0; c < 4; c++) expect_column(c, 0, 3, c == 3);
    fork
      push_wpacket(0, 3, 4);
      push_image(4);
    join
    finish_test("back-pressure");
    rand_ready = 1'b0;
    gaps = 1'b0;
  endtask

  task automatic test_reload();
    fill_weights(1);
    for (int c = 0; c < 4; c++) expect_column(c, (c < 2) ? 0 : 1, 3, c == 3);
    fork
      begin
        push_wpacket(0, 3, 2);
        push_wpacket(1, 3, 2);
      end
      push_image(4);
    join
    finish_test("weight reload");
  endtask

  initial begin
    i_rst_n = 1'b0;
    i_px_valid = 1'b0;
    i_px_data = '0;
    i_px_last = 1'b0;
    i_w_valid = 1'b0;
    i_w_data = '0;
    i_w_last = 1'b0;
    i_m_ready = 1'b1;
    rand_ready = 1'b0;
    gaps = 1'b0;
    w_seed = seed ^ 32'h0000_0011;
    px_seed = seed ^ 32'h0000_0022;
    ready_seed = seed ^ 32'h0000_0033;
    repeat (4) @(posedge aclk);
    i_rst_n <= 1'b1;
    @(posedge aclk);
    test_after_reset();
    test_kernel3();
    test_kernel1();
    test_backpressure();
    test_reload();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: conv_input_pipe.f
+incdir+include
src/conv_in_pkg.sv
src/conv_stream_if.sv
src/pixel_shifter.sv
src/weight_rotator.sv
src/beat_joiner.sv
src/conv_input_pipe.sv
bench/conv_input_pipe_tb.sv

// File: Makefile
TOOL      = verilator
FLAGS     = --binary --timing -Wno-fatal
TOP       = conv_input_pipe_tb
FILELIST  = conv_input_pipe.f
BUILD_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the simulation"
	@echo "  clean  remove the build output"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q 'All tests passed!'

clean:
	rm -rf $(BUILD_DIR)
